// ==== src/mips_core_pkg.sv ====
`default_nettype none

package mips_core_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;
    localparam int REG_NUM    = 32;

    // sll r0 r0 0 and sll r0 r0 1
    localparam logic [INST_W-1:0] INST_NOP   = 32'h0000_0000;
    localparam logic [INST_W-1:0] INST_SSNOP = 32'h0000_0040;

    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011,
        OP_ANDI     = 6'b001100,
        OP_ORI      = 6'b001101,
        OP_XORI     = 6'b001110,
        OP_LUI      = 6'b001111,
        OP_SPECIAL2 = 6'b011100,
        OP_PREF     = 6'b110011
    } opcode_e;

    typedef enum logic [5:0] {
        FUNC_SLL  = 6'b000000,
        FUNC_SRL  = 6'b000010,
        FUNC_SRA  = 6'b000011,
        FUNC_SLLV = 6'b000100,
        FUNC_SRLV = 6'b000110,
        FUNC_SRAV = 6'b000111,
        FUNC_MOVZ = 6'b001010,
        FUNC_MOVN = 6'b001011,
        FUNC_SYNC = 6'b001111,
        FUNC_ADD  = 6'b100000,
        FUNC_ADDU = 6'b100001,
        FUNC_SUB  = 6'b100010,
        FUNC_SUBU = 6'b100011,
        FUNC_AND  = 6'b100100,
        FUNC_OR   = 6'b100101,
        FUNC_XOR  = 6'b100110,
        FUNC_NOR  = 6'b100111,
        FUNC_SLT  = 6'b101010,
        FUNC_SLTU = 6'b101011
    } func_e;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_AND  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_ADD  = 4'd8,
        ALU_SUB  = 4'd9,
        ALU_SLT  = 4'd10,
        ALU_SLTU = 4'd11,
        ALU_MOVN = 4'd12,
        ALU_MOVZ = 4'd13
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  reg1_re;
        logic [REG_ADDR_W-1:0] reg1_addr;
        logic                  reg2_re;
        logic [REG_ADDR_W-1:0] reg2_addr;
        logic [DATA_W-1:0]     imm;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic                  inst_ok;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     op1;
        logic [DATA_W-1:0]     op2;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic                  invalid;
    } ex_req_t;

    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     data;
        logic                  invalid;
    } wb_bus_t;

endpackage

`default_nettype wire

// ==== src/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder
    import mips_core_pkg::*;
(
    input  wire [INST_W-1:0] inst_i,
    output dec_ctrl_t        ctrl_o
);

    opcode_e               opcode;
    func_e                 func;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            shamt;
    logic [15:0]           imm16;
    alu_op_e               fn_op;
    alu_op_e               imm_op;
    logic [DATA_W-1:0]     imm_ext;
    logic                  is_nop;
    logic                  fixed_shift;

    assign opcode = opcode_e'(inst_i[31:26]);
    assign func   = func_e'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign imm16  = inst_i[15:0];

    assign is_nop      = (inst_i == INST_NOP) || (inst_i == INST_SSNOP);
    assign fixed_shift = (func == FUNC_SLL) || (func == FUNC_SRL) || (func == FUNC_SRA);

    // special group function to execute op
    always_comb begin
        case (func)
            FUNC_AND:             fn_op = ALU_AND;
            FUNC_OR:              fn_op = ALU_OR;
            FUNC_XOR:             fn_op = ALU_XOR;
            FUNC_NOR:             fn_op = ALU_NOR;
            FUNC_SLL, FUNC_SLLV:  fn_op = ALU_SLL;
            FUNC_SRL, FUNC_SRLV:  fn_op = ALU_SRL;
            FUNC_SRA, FUNC_SRAV:  fn_op = ALU_SRA;
            FUNC_ADD, FUNC_ADDU:  fn_op = ALU_ADD;
            FUNC_SUB, FUNC_SUBU:  fn_op = ALU_SUB;
            FUNC_SLT:             fn_op = ALU_SLT;
            FUNC_SLTU:            fn_op = ALU_SLTU;
            FUNC_MOVN:            fn_op = ALU_MOVN;
            FUNC_MOVZ:            fn_op = ALU_MOVZ;
            default:              fn_op = ALU_NOP;
        endcase
    end

    // immediate forms
    always_comb begin
        case (opcode)
            OP_ANDI:            imm_op = ALU_AND;
            OP_ORI, OP_LUI:     imm_op = ALU_OR;
            OP_XORI:            imm_op = ALU_XOR;
            OP_ADDI, OP_ADDIU:  imm_op = ALU_ADD;
            OP_SLTI:            imm_op = ALU_SLT;
            OP_SLTIU:           imm_op = ALU_SLTU;
            default:            imm_op = ALU_NOP;
        endcase

        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI: imm_ext = {16'h0000, imm16};
            OP_LUI:                   imm_ext = {imm16, 16'h0000};
            default:                  imm_ext = {{16{imm16[15]}}, imm16};
        endcase
    end

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            OP_SPECIAL: begin
                if (is_nop) begin
                    ctrl_o.inst_ok = 1'b1;
                end else if (shamt == 5'd0 || fixed_shift) begin
                    case (func)
                        FUNC_SLL, FUNC_SRL, FUNC_SRA: begin
                            // rt shifted by the shamt field
                            ctrl_o.alu_op    = fn_op;
                            ctrl_o.reg1_re   = 1'b1;
                            ctrl_o.reg1_addr = rt;
                            ctrl_o.imm       = DATA_W'(shamt);
                            ctrl_o.we        = 1'b1;
                            ctrl_o.waddr     = rd;
                            ctrl_o.inst_ok   = 1'b1;
                        end
                        FUNC_SLLV, FUNC_SRLV, FUNC_SRAV: begin
                            // rt shifted by rs
                            ctrl_o.alu_op    = fn_op;
                            ctrl_o.reg1_re   = 1'b1;
                            ctrl_o.reg1_addr = rt;
                            ctrl_o.reg2_re   = 1'b1;
                            ctrl_o.reg2_addr = rs;
                            ctrl_o.we        = 1'b1;
                            ctrl_o.waddr     = rd;
                            ctrl_o.inst_ok   = 1'b1;
                        end
                        FUNC_SYNC: begin
                            ctrl_o.inst_ok = 1'b1;
                        end
                        default: begin
                            if (fn_op != ALU_NOP) begin
                                ctrl_o.alu_op    = fn_op;
                                ctrl_o.reg1_re   = 1'b1;
                                ctrl_o.reg1_addr = rs;
                                ctrl_o.reg2_re   = 1'b1;
                                ctrl_o.reg2_addr = rt;
                                ctrl_o.we        = 1'b1;
                                ctrl_o.waddr     = rd;
                                ctrl_o.inst_ok   = 1'b1;
                            end
                        end
                    endcase
                end
            end
            OP_SPECIAL2: begin
                // no special2 function is implemented
                ctrl_o.inst_ok = 1'b0;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl_o.alu_op    = imm_op;
                // lui ors the shifted immediate into zero
                ctrl_o.reg1_re   = (opcode != OP_LUI);
                ctrl_o.reg1_addr = rs;
                ctrl_o.imm       = imm_ext;
                ctrl_o.we        = 1'b1;
                ctrl_o.waddr     = rt;
                ctrl_o.inst_ok   = 1'b1;
            end
            OP_PREF: begin
                ctrl_o.inst_ok = 1'b1;
            end
            default: begin
                ctrl_o.inst_ok = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file
    import mips_core_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire [REG_ADDR_W-1:0] rd1_addr_i,
    input  wire [REG_ADDR_W-1:0] rd2_addr_i,
    output logic [DATA_W-1:0]    rd1_data_o,
    output logic [DATA_W-1:0]    rd2_data_o,
    input  wire wb_bus_t         ex_fwd_i,
    input  wire wb_bus_t         wb_i
);

    logic [DATA_W-1:0] regs [REG_NUM];

    // r0 is never written
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.we && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    function automatic logic hit(input wb_bus_t bus, input logic [REG_ADDR_W-1:0] addr);
        return bus.valid && bus.we && (bus.addr == addr);
    endfunction

    // execute result first, then write-back, then storage
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        logic [DATA_W-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (hit(ex_fwd_i, addr)) begin
            val = ex_fwd_i.data;
        end else if (hit(wb_i, addr)) begin
            val = wb_i.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rd1_data_o = read_reg(rd1_addr_i);
        rd2_data_o = read_reg(rd2_addr_i);
    end

endmodule

`default_nettype wire

// ==== src/operand_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_stage
    import mips_core_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              inst_valid_i,
    input  wire dec_ctrl_t   ctrl_i,
    input  wire [DATA_W-1:0] rd1_data_i,
    input  wire [DATA_W-1:0] rd2_data_i,
    output ex_req_t          req_o
);

    logic [DATA_W-1:0] op1;
    logic [DATA_W-1:0] op2;

    // operand select
    assign op1 = ctrl_i.reg1_re ? rd1_data_i : '0;
    assign op2 = ctrl_i.reg2_re ? rd2_data_i : ctrl_i.imm;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_o <= '0;
        end else begin
            req_o.valid  <= inst_valid_i;
            req_o.alu_op <= ctrl_i.alu_op;
            req_o.op1    <= op1;
            req_o.op2    <= op2;
            req_o.waddr  <= ctrl_i.waddr;
            // a bubble carries neither a write nor an invalid flag
            req_o.we      <= inst_valid_i & ctrl_i.we;
            req_o.invalid <= inst_valid_i & ~ctrl_i.inst_ok;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
    import mips_core_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire ex_req_t   req_i,
    output wb_bus_t        ex_fwd_o,
    output wb_bus_t        wb_o
);

    logic [DATA_W-1:0] result;
    logic              wr_en;
    logic [4:0]        sa;

    assign sa = req_i.op2[4:0];

    always_comb begin
        result = '0;
        wr_en  = req_i.we;
        case (req_i.alu_op)
            ALU_AND:  result = req_i.op1 & req_i.op2;
            ALU_OR:   result = req_i.op1 | req_i.op2;
            ALU_XOR:  result = req_i.op1 ^ req_i.op2;
            ALU_NOR:  result = ~(req_i.op1 | req_i.op2);
            ALU_SLL:  result = req_i.op1 << sa;
            ALU_SRL:  result = req_i.op1 >> sa;
            ALU_SRA:  result = $signed(req_i.op1) >>> sa;
            ALU_ADD:  result = req_i.op1 + req_i.op2;
            ALU_SUB:  result = req_i.op1 - req_i.op2;
            ALU_SLT:  result = DATA_W'($signed(req_i.op1) < $signed(req_i.op2));
            ALU_SLTU: result = DATA_W'(req_i.op1 < req_i.op2);
            ALU_MOVN: begin
                // write only when rt is nonzero
                result = req_i.op1;
                wr_en  = req_i.we && (req_i.op2 != '0);
            end
            ALU_MOVZ: begin
                result = req_i.op1;
                wr_en  = req_i.we && (req_i.op2 == '0);
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign ex_fwd_o.valid   = req_i.valid;
    assign ex_fwd_o.we      = wr_en;
    assign ex_fwd_o.addr    = req_i.waddr;
    assign ex_fwd_o.data    = result;
    assign ex_fwd_o.invalid = req_i.invalid;

    // write-back stage
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= ex_fwd_o;
        end
    end

endmodule

`default_nettype wire

// ==== src/mips_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module mips_core
    import mips_core_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n_i,
    input  wire              inst_valid_i,
    input  wire [INST_W-1:0] inst_i,
    output wb_bus_t          wb_o
);

    dec_ctrl_t         dec_ctrl;
    logic [DATA_W-1:0] rd1_data;
    logic [DATA_W-1:0] rd2_data;
    ex_req_t           ex_req;
    wb_bus_t           ex_fwd;

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .ctrl_o (dec_ctrl)
    );

    // reads in the presentation cycle
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd1_addr_i (dec_ctrl.reg1_addr),
        .rd2_addr_i (dec_ctrl.reg2_addr),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data),
        .ex_fwd_i   (ex_fwd),
        .wb_i       (wb_o)
    );

    operand_stage u_operand_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .ctrl_i       (dec_ctrl),
        .rd1_data_i   (rd1_data),
        .rd2_data_i   (rd2_data),
        .req_o        (ex_req)
    );

    // execute and write-back stage
    alu u_alu (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .req_i    (ex_req),
        .ex_fwd_o (ex_fwd),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// architectural registers as seen after each issued instruction
logic [31:0] shadow [32];

function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// expected write-back record that also retires the result into the shadow file
function automatic wb_bus_t predict(input logic [31:0] inst);
    wb_bus_t     r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] si;
    logic [31:0] zi;
    logic [4:0]  sh;
    a  = shadow[inst[25:21]];
    b  = shadow[inst[20:16]];
    si = {{16{inst[15]}}, inst[15:0]};
    zi = {16'h0000, inst[15:0]};
    sh = inst[10:6];
    r  = '0;
    r.valid = 1'b1;
    r.we    = 1'b1;
    r.addr  = (inst[31:26] == 6'h00) ? inst[15:11] : inst[20:16];
    case (inst[31:26])
        6'h00: begin
            case (inst[5:0])
                6'h00: r.data = b << sh;
                6'h02: r.data = b >> sh;
                6'h03: r.data = $signed(b) >>> sh;
                6'h04: r.data = b << a[4:0];
                6'h06: r.data = b >> a[4:0];
                6'h07: r.data = $signed(b) >>> a[4:0];
                6'h0a, 6'h0b: begin
                    // movz writes on a zero rt, movn on a nonzero one
                    r.data = a;
                    r.we   = (b == 32'h0) ^ inst[0];
                end
                6'h0f: r.we = 1'b0;
                6'h20, 6'h21: r.data = a + b;
                6'h22, 6'h23: r.data = a - b;
                6'h24: r.data = a & b;
                6'h25: r.data = a | b;
                6'h26: r.data = a ^ b;
                6'h27: r.data = ~(a | b);
                6'h2a: r.data = 32'($signed(a) < $signed(b));
                6'h2b: r.data = 32'(a < b);
                default: r.invalid = 1'b1;
            endcase
            // only the fixed shifts carry a shift amount
            if (sh != 5'd0 && inst[5:0] > 6'h03) begin
                r.invalid = 1'b1;
            end
            if (inst == 32'h0000_0000 || inst == 32'h0000_0040) begin
                r.we = 1'b0;
            end
        end
        6'h08, 6'h09: r.data = a + si;
        6'h0a: r.data = 32'($signed(a) < $signed(si));
        6'h0b: r.data = 32'(a < si);
        6'h0c: r.data = a & zi;
        6'h0d: r.data = a | zi;
        6'h0e: r.data = a ^ zi;
        6'h0f: r.data = {inst[15:0], 16'h0000};
        6'h33: r.we = 1'b0;
        default: r.invalid = 1'b1;
    endcase
    if (r.invalid) begin
        r.we = 1'b0;
    end
    if (r.we && r.addr != 5'd0) begin
        shadow[r.addr] = r.data;
    end
    return r;
endfunction

`endif

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core
    import mips_core_pkg::*;
();

    // issue slots of the six tests, then drains and reset on top
    localparam int N_SLOTS     = 1 + 16 + (8 + 32) + 11 + 9 + 24;
    localparam int WATCHDOG_NS = (N_SLOTS + 6 * 4 + 20) * 20;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    wb_bus_t     wb_o;

    integer  seed = 32'h6d5d65e6;
    int      cycle = 0;
    int      n_checks = 0;
    int      n_errs = 0;
    int      test_errs = 0;
    int      test_num = 0;
    wb_bus_t exp_q[$];
    int      due_q[$];
    func_e   fn_list [16] = '{FUNC_ADD, FUNC_SLL, FUNC_SUB, FUNC_SRLV, FUNC_AND, FUNC_SRA,
                              FUNC_OR, FUNC_SLLV, FUNC_XOR, FUNC_SRL, FUNC_NOR, FUNC_SRAV,
                              FUNC_SLT, FUNC_ADDU, FUNC_SLTU, FUNC_SUBU};

    `include "tb_ref_model.svh"

    mips_core uut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_o         (wb_o)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        n_checks++;
        assert (got == want) else begin
            n_errs++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    // a record is due two edges after the edge that captured it
    always @(negedge clk) begin
        wb_bus_t want;
        cycle = cycle + 1;
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            want = exp_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            want = '0;
        end
        check_field("wb_o.valid", 32'(wb_o.valid), 32'(want.valid));
        check_field("wb_o.we", 32'(wb_o.we), 32'(want.we));
        check_field("wb_o.invalid", 32'(wb_o.invalid), 32'(want.invalid));
        if (want.we) begin
            check_field("wb_o.addr", 32'(wb_o.addr), 32'(want.addr));
            check_field("wb_o.data", wb_o.data, want.data);
        end
    end

    task automatic issue(input logic [31:0] inst);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        exp_q.push_back(predict(inst));
        due_q.push_back(cycle + 3);
    endtask

    // valid low with junk on the instruction bus
    task automatic idle_slot();
        @(posedge clk);
        inst_valid_i <= 1'b0;
        inst_i       <= $random(seed);
        exp_q.push_back('0);
        due_q.push_back(cycle + 3);
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        inst_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, n_errs - test_errs);
        test_errs = n_errs;
    endtask

    initial begin
        logic [4:0] rd;
        logic [4:0] sh;
        func_e      fn;
        rst_n_i      <= 1'b0;
        inst_valid_i <= 1'b0;
        inst_i       <= '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        issue(enc_i(OP_LUI, 5'd0, 5'd1, 16'h1234));
        end_test("reset and latency");

        for (int k = 0; k < 2; k++) begin
            issue(enc_i(OP_LUI, 5'd0, 5'd2, 16'($random(seed))));
            issue(enc_i(OP_ORI, 5'd2, 5'd2, 16'($random(seed))));
            issue(enc_i(OP_ANDI, 5'd2, 5'd3, 16'($random(seed))));
            issue(enc_i(OP_XORI, 5'd2, 5'd4, 16'($random(seed))));
            issue(enc_i(OP_ADDI, 5'd4, 5'd5, 16'($random(seed))));
            issue(enc_i(OP_ADDIU, 5'd5, 5'd6, 16'($random(seed))));
            issue(enc_i(OP_SLTI, 5'd6, 5'd7, 16'($random(seed))));
            issue(enc_i(OP_SLTIU, 5'd6, 5'd8, 16'($random(seed))));
        end
        end_test("immediate ops");

        for (int i = 9; i < 13; i++) begin
            issue(enc_i(OP_LUI, 5'd0, 5'(i), 16'($random(seed))));
            issue(enc_i(OP_ORI, 5'(i), 5'(i), 16'($random(seed))));
        end
        // rs from the previous result, rt from the one before it
        for (int k = 0; k < 32; k++) begin
            fn = fn_list[k % 16];
            sh = (fn == FUNC_SLL || fn == FUNC_SRL || fn == FUNC_SRA) ?
                 5'($random(seed)) : 5'd0;
            issue(enc_r(fn, 5'(9 + (k + 3) % 4), 5'(9 + (k + 2) % 4), 5'(9 + k % 4), sh));
        end
        end_test("r-type with bypass");

        issue(enc_i(OP_ORI, 5'd0, 5'd14, 16'($random(seed)) | 16'h0001));
        issue(enc_r(FUNC_ADDU, 5'd0, 5'd0, 5'd15, 5'd0));
        issue(enc_i(OP_LUI, 5'd0, 5'd16, 16'($random(seed))));
        issue(enc_i(OP_ORI, 5'd0, 5'd18, 16'haaaa));
        issue(enc_i(OP_ORI, 5'd0, 5'd20, 16'h5555));
        issue(enc_r(FUNC_MOVN, 5'd16, 5'd14, 5'd17, 5'd0));
        issue(enc_r(FUNC_MOVN, 5'd16, 5'd15, 5'd18, 5'd0));
        issue(enc_r(FUNC_MOVZ, 5'd16, 5'd15, 5'd19, 5'd0));
        issue(enc_r(FUNC_MOVZ, 5'd16, 5'd14, 5'd20, 5'd0));
        // skipped moves must leave r18 and r20 alone
        issue(enc_r(FUNC_OR, 5'd18, 5'd0, 5'd21, 5'd0));
        issue(enc_r(FUNC_OR, 5'd20, 5'd0, 5'd22, 5'd0));
        end_test("conditional moves");

        issue(32'h0000_0000);
        issue(32'h0000_0040);
        issue(enc_r(FUNC_SYNC, 5'd0, 5'd0, 5'd0, 5'd0));
        issue(enc_i(OP_PREF, 5'd2, 5'd1, 16'h0010));
        issue(enc_i(6'h3f, 5'd2, 5'd3, 16'h0001));
        issue({6'h1c, 5'd2, 5'd3, 5'd4, 5'd0, 6'h02});
        issue(enc_r(FUNC_ADDU, 5'd2, 5'd3, 5'd4, 5'd7));
        issue(enc_i(OP_ADDIU, 5'd2, 5'd0, 16'h7777));
        issue(enc_r(FUNC_OR, 5'd0, 5'd0, 5'd23, 5'd0));
        end_test("no-ops, invalid and r0");

        for (int k = 0; k < 24; k++) begin
            if ($random(seed) & 32'h1) begin
                idle_slot();
            end else begin
                rd = 5'(2 + k % 7);
                issue(enc_r(FUNC_ADDU, rd, 5'(2 + (k + 6) % 7), rd, 5'd0));
            end
        end
        end_test("random bubbles");

        $display("%0d tests, %0d checks, %0d errors", test_num, n_checks, n_errs);
        if (n_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
+incdir+tests
src/mips_core_pkg.sv
src/inst_decoder.sv
src/reg_file.sv
src/operand_stage.sv
src/alu.sv
src/mips_core.sv
tests/tb_mips_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_mips_core -f mips_core.f -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -x "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
